/* logic/cart_mem_pkg.sv */
package cart_mem_pkg;

  // memory address width, also used for the masks
  localparam int ADDR_W = 24;

  //////////////////////////////////////////////////
  // mapper select

  // codes 3 to 7 all select custom mapper variants
  typedef enum logic [2:0] {
    map_hirom   = 3'd0,
    map_lorom   = 3'd1,
    map_exhirom = 3'd2,
    map_custom  = 3'd3
  } mapper_e;

  // mapper after reset
  localparam mapper_e MAPPER_RST = map_lorom;

endpackage

/* logic/mcu_cmd_pkg.sv */
package mcu_cmd_pkg;

  // byte-in-transfer counter, saturates at all ones
  localparam int BYTE_CNT_W = 8;

  // console clock count width, sent as four reply bytes
  localparam int FREQ_W = 32;

  //////////////////////////////////////////////////
  // command byte decoding

  // upper nibble of the command byte
  typedef enum logic [3:0] {
    grp_addr      = 4'h0,
    grp_rom_mask  = 4'h1,
    grp_sram_mask = 4'h2,
    grp_mapper    = 4'h3,
    grp_read      = 4'h8,
    grp_write     = 4'h9,
    grp_query     = 4'hF
  } cmd_grp_e;

  // full query commands
  typedef enum logic [7:0] {
    q_sig  = 8'hF0,
    q_freq = 8'hFE,
    q_echo = 8'hFF
  } query_e;

  //////////////////////////////////////////////////
  // reply constants

  localparam logic [7:0] SIG_BYTE = 8'hA5;

  // command bit for address auto-increment on read/write
  localparam int INC_BIT = 3;

endpackage

/* logic/spi_slave.sv */
module spi_slave (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 sck,
  input  logic                                 mosi,
  input  logic                                 ss_n,
  input  logic [7:0]                           tx_data,
  output logic                                 miso,
  output logic                                 cmd_ready,
  output logic                                 param_ready,
  output logic [7:0]                           cmd_data,
  output logic [7:0]                           param_data,
  output logic [mcu_cmd_pkg::BYTE_CNT_W-1:0]   byte_cnt
);
  import mcu_cmd_pkg::*;

  logic [2:0] sck_q;
  logic [2:0] ss_q;
  logic [1:0] mosi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       ss_fall;
  logic       ss_active;
  logic [2:0] bit_cnt;
  logic       byte_end;
  logic       first_byte;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;

  //////////////////////////////////////////////////
  // pin synchronizers

  // mosi gets the same depth as sck so the sample lines up
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_q  <= '0;
      ss_q   <= '1;
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      ss_q   <= {ss_q[1:0], ss_n};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  assign sck_rise  = sck_q[1] & ~sck_q[2];
  assign sck_fall  = ~sck_q[1] & sck_q[2];
  assign ss_fall   = ~ss_q[1] & ss_q[2];
  assign ss_active = ~ss_q[1];

  //////////////////////////////////////////////////
  // byte framing

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt  <= '0;
      byte_end <= 1'b0;
    end else begin
      byte_end <= 1'b0;
      if (!ss_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;
        byte_end <= (bit_cnt == 3'd7);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ss_active && sck_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_q[1]};
    end
  end

  // strobes come one cycle after the last bit lands
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cmd_ready   <= 1'b0;
      param_ready <= 1'b0;
      first_byte  <= 1'b0;
      cmd_data    <= '0;
      byte_cnt    <= '0;
    end else begin
      cmd_ready   <= byte_end & first_byte;
      param_ready <= byte_end & ~first_byte;
      if (ss_fall) begin
        first_byte <= 1'b1;
        byte_cnt   <= '0;
      end else if (byte_end) begin
        first_byte <= 1'b0;
        if (first_byte) begin
          cmd_data <= rx_shift;
        end
        if (byte_cnt != '1) begin
          byte_cnt <= byte_cnt + BYTE_CNT_W'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_end) begin
      param_data <= rx_shift;
    end
  end

  // reply follows tx_data until the first bit of a byte is sampled
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_shift <= '0;
    end else if (bit_cnt == 3'd0 && !(ss_active && sck_rise)) begin
      tx_shift <= tx_data;
    end else if (sck_fall && bit_cnt != 3'd0) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign miso = tx_shift[7];

endmodule

/* logic/mcu_cmd.sv */
module mcu_cmd (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                cmd_ready,
  input  logic                                param_ready,
  input  logic [7:0]                          cmd_data,
  input  logic [7:0]                          param_data,
  input  logic [mcu_cmd_pkg::BYTE_CNT_W-1:0]  byte_cnt,
  output logic [7:0]                          tx_data,
  output logic                                rd_start,
  output logic                                wr_start,
  output logic [7:0]                          wdata,
  input  logic                                done,
  input  logic [7:0]                          rdata,
  output logic [cart_mem_pkg::ADDR_W-1:0]     addr,
  input  logic [mcu_cmd_pkg::FREQ_W-1:0]      freq_count,
  output cart_mem_pkg::mapper_e               mapper,
  output logic [cart_mem_pkg::ADDR_W-1:0]     rom_mask,
  output logic [cart_mem_pkg::ADDR_W-1:0]     saveram_mask
);
  import cart_mem_pkg::*;
  import mcu_cmd_pkg::*;

  cmd_grp_e          grp;
  logic              inc_en;
  logic [FREQ_W-9:0] freq_lo;

  assign grp    = cmd_grp_e'(cmd_data[7:4]);
  assign inc_en = cmd_data[INC_BIT] && (grp == grp_read || grp == grp_write);

  // big-endian load from bytes 2 to 4, byte 2 clears the rest
  function automatic logic [ADDR_W-1:0] load_be(
    input logic [ADDR_W-1:0]     cur,
    input logic [BYTE_CNT_W-1:0] cnt,
    input logic [7:0]            data
  );
    logic [ADDR_W-1:0] nxt;
    nxt = cur;
    case (cnt)
      BYTE_CNT_W'(2): nxt = {data, {(ADDR_W - 8){1'b0}}};
      BYTE_CNT_W'(3): nxt[ADDR_W-9 -: 8] = data;
      BYTE_CNT_W'(4): nxt[ADDR_W-17 -: 8] = data;
      default: ;
    endcase
    return nxt;
  endfunction

  //////////////////////////////////////////////////
  // cartridge configuration

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mapper       <= MAPPER_RST;
      rom_mask     <= '0;
      saveram_mask <= '0;
    end else if (cmd_ready) begin
      if (grp == grp_mapper) begin
        mapper <= mapper_e'(cmd_data[2:0]);
      end
    end else if (param_ready) begin
      if (grp == grp_rom_mask) begin
        rom_mask <= load_be(rom_mask, byte_cnt, param_data);
      end
      if (grp == grp_sram_mask) begin
        saveram_mask <= load_be(saveram_mask, byte_cnt, param_data);
      end
    end
  end

  //////////////////////////////////////////////////
  // address pointer and memory requests

  // step once per finished access when the inc bit is set
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      addr <= '0;
    end else if (param_ready && grp == grp_addr) begin
      addr <= load_be(addr, byte_cnt, param_data);
    end else if (done && inc_en) begin
      addr <= addr + ADDR_W'(1);
    end
  end

  // reads also fire on the command byte itself
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_start <= 1'b0;
      wr_start <= 1'b0;
    end else begin
      rd_start <= (cmd_ready || param_ready) && grp == grp_read;
      wr_start <= param_ready && grp == grp_write;
    end
  end

  always_ff @(posedge clk) begin
    if (param_ready && grp == grp_write) begin
      wdata <= param_data;
    end
  end

  //////////////////////////////////////////////////
  // reply byte

  // low bytes of the count, frozen at the command byte
  always_ff @(posedge clk) begin
    if (cmd_ready && cmd_data == q_freq) begin
      freq_lo <= freq_count[FREQ_W-9:0];
    end
  end

  // formed for byte n, shifted out during byte n+1
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_data <= '0;
    end else if (done && grp == grp_read) begin
      tx_data <= rdata;
    end else if (cmd_ready || param_ready) begin
      case (cmd_data)
        q_sig: begin
          tx_data <= SIG_BYTE;
        end
        q_echo: begin
          if (param_ready) begin
            tx_data <= param_data;
          end
        end
        q_freq: begin
          case (byte_cnt)
            BYTE_CNT_W'(1): tx_data <= freq_count[FREQ_W-1 -: 8];
            BYTE_CNT_W'(2): tx_data <= freq_lo[FREQ_W-9 -: 8];
            BYTE_CNT_W'(3): tx_data <= freq_lo[FREQ_W-17 -: 8];
            BYTE_CNT_W'(4): tx_data <= freq_lo[7:0];
            default: tx_data <= '0;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

/* logic/mem_req.sv */
module mem_req (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       rd_start,
  input  logic       wr_start,
  output logic       mem_rd,
  output logic       mem_wr,
  input  logic       mem_ready,
  input  logic [7:0] mem_rdata,
  output logic       done,
  output logic [7:0] rdata
);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_done
  } state_e;

  state_e     state;
  logic [2:0] rdy_q;
  logic       rdy_rise;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdy_q <= '0;
    end else begin
      rdy_q <= {rdy_q[1:0], mem_ready};
    end
  end

  assign rdy_rise = rdy_q[1] & ~rdy_q[2];

  // one request at a time, starts while busy are dropped
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= st_idle;
      mem_rd <= 1'b0;
      mem_wr <= 1'b0;
    end else begin
      mem_rd <= 1'b0;
      mem_wr <= 1'b0;
      case (state)
        st_idle: begin
          if (rd_start || wr_start) begin
            mem_rd <= rd_start;
            mem_wr <= ~rd_start;
            state  <= st_wait;
          end
        end
        st_wait: begin
          if (rdy_rise) begin
            state <= st_done;
          end
        end
        st_done: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // mem_rdata stays valid until the next request
  always_ff @(posedge clk) begin
    if (state == st_wait && rdy_rise) begin
      rdata <= mem_rdata;
    end
  end

  assign done = (state == st_done);

endmodule

/* logic/clk_meter.sv */
module clk_meter #(
  parameter int GATE_CYCLES = 3000
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            snes_sysclk,
  output logic [mcu_cmd_pkg::FREQ_W-1:0]  freq_count
);
  import mcu_cmd_pkg::*;

  localparam int GATE_W = $clog2(GATE_CYCLES + 1);

  logic [2:0]        sys_q;
  logic              sys_rise;
  logic [GATE_W-1:0] gate_cnt;
  logic              gate_end;
  logic [FREQ_W-1:0] edge_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sys_q <= '0;
    end else begin
      sys_q <= {sys_q[1:0], snes_sysclk};
    end
  end

  assign sys_rise = sys_q[1] & ~sys_q[2];
  assign gate_end = (gate_cnt == GATE_W'(GATE_CYCLES - 1));

  //////////////////////////////////////////////////
  // gate window

  // last edge of a window still counts toward it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gate_cnt   <= '0;
      edge_cnt   <= '0;
      freq_count <= '0;
    end else if (gate_end) begin
      gate_cnt   <= '0;
      edge_cnt   <= '0;
      freq_count <= edge_cnt + FREQ_W'(sys_rise);
    end else begin
      gate_cnt <= gate_cnt + GATE_W'(1);
      edge_cnt <= edge_cnt + FREQ_W'(sys_rise);
    end
  end

endmodule

/* logic/cart_ctrl.sv */
module cart_ctrl #(
  parameter int GATE_CYCLES = 3000
) (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             sck,
  input  logic                             mosi,
  input  logic                             ss_n,
  output logic                             miso,
  input  logic                             snes_sysclk,
  output logic [cart_mem_pkg::ADDR_W-1:0]  mem_addr,
  output logic                             mem_rd,
  output logic                             mem_wr,
  output logic [7:0]                       mem_wdata,
  input  logic [7:0]                       mem_rdata,
  input  logic                             mem_ready,
  output cart_mem_pkg::mapper_e            mapper,
  output logic [cart_mem_pkg::ADDR_W-1:0]  rom_mask,
  output logic [cart_mem_pkg::ADDR_W-1:0]  saveram_mask
);
  import mcu_cmd_pkg::*;

  logic                  cmd_ready;
  logic                  param_ready;
  logic [7:0]            cmd_data;
  logic [7:0]            param_data;
  logic [BYTE_CNT_W-1:0] byte_cnt;
  logic [7:0]            tx_data;
  logic                  rd_start;
  logic                  wr_start;
  logic                  done;
  logic [7:0]            rdata;
  logic [FREQ_W-1:0]     freq_count;

  spi_slave u_spi (
    .clk         (clk),
    .arst_n      (arst_n),
    .sck         (sck),
    .mosi        (mosi),
    .ss_n        (ss_n),
    .tx_data     (tx_data),
    .miso        (miso),
    .cmd_ready   (cmd_ready),
    .param_ready (param_ready),
    .cmd_data    (cmd_data),
    .param_data  (param_data),
    .byte_cnt    (byte_cnt)
  );

  mcu_cmd u_cmd (
    .clk          (clk),
    .arst_n       (arst_n),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .byte_cnt     (byte_cnt),
    .tx_data      (tx_data),
    .rd_start     (rd_start),
    .wr_start     (wr_start),
    .wdata        (mem_wdata),
    .done         (done),
    .rdata        (rdata),
    .addr         (mem_addr),
    .freq_count   (freq_count),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask)
  );

  mem_req u_mem (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_start  (rd_start),
    .wr_start  (wr_start),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .done      (done),
    .rdata     (rdata)
  );

  clk_meter #(
    .GATE_CYCLES (GATE_CYCLES)
  ) u_meter (
    .clk         (clk),
    .arst_n      (arst_n),
    .snes_sysclk (snes_sysclk),
    .freq_count  (freq_count)
  );

endmodule

/* dv/cart_ctrl_assert.sv */
module cart_ctrl_assert (
  input logic clk,
  input logic arst_n,
  input logic mem_rd,
  input logic mem_wr,
  input logic mem_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  logic pending;
  int   err_cnt = 0;

  // request seen and mem_ready not yet returned
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= 1'b0;
    end else if (mem_ready) begin
      pending <= 1'b0;
    end else if (mem_rd || mem_wr) begin
      pending <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // memory port rules

  rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n) !(mem_rd && mem_wr))
    else begin
      $error("mem_rd and mem_wr are high in the same cycle");
      err_cnt++;
    end

  rd_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) mem_rd |=> !mem_rd)
    else begin
      $error("mem_rd pulse is longer than one cycle");
      err_cnt++;
    end

  wr_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) mem_wr |=> !mem_wr)
    else begin
      $error("mem_wr pulse is longer than one cycle");
      err_cnt++;
    end

  no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
    (mem_rd || mem_wr) |-> !pending)
    else begin
      $error("new memory request issued before mem_ready of the previous one");
      err_cnt++;
    end

endmodule

bind cart_ctrl cart_ctrl_assert u_assert (
  .clk       (clk),
  .arst_n    (arst_n),
  .mem_rd    (mem_rd),
  .mem_wr    (mem_wr),
  .mem_ready (mem_ready)
);

/* dv/cart_ctrl_tb.sv */
module cart_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import cart_mem_pkg::*;
  import mcu_cmd_pkg::*;

  localparam int GATE        = 3000;
  localparam int CYCLE_LIMIT = 100000;

  logic              clk;
  logic              arst_n;
  logic              sck;
  logic              mosi;
  logic              ss_n;
  logic              miso;
  logic              snes_sysclk;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_rd;
  logic              mem_wr;
  logic [7:0]        mem_wdata;
  logic [7:0]        mem_rdata;
  logic              mem_ready;
  mapper_e           mapper;
  logic [ADDR_W-1:0] rom_mask;
  logic [ADDR_W-1:0] saveram_mask;

  logic [31:0]       seed;
  int                cyc = 0;
  logic [7:0]        tx_buf [0:31];
  logic [7:0]        rx_buf [0:31];
  logic [7:0]        wdat [0:31];
  logic [7:0]        mem [0:255];
  logic [ADDR_W-1:0] wr_addr_log [0:31];
  logic [7:0]        wr_data_log [0:31];
  int                wr_cnt;
  logic              mem_busy;

  cart_ctrl #(
    .GATE_CYCLES (GATE)
  ) u_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .sck          (sck),
    .mosi         (mosi),
    .ss_n         (ss_n),
    .miso         (miso),
    .snes_sysclk  (snes_sysclk),
    .mem_addr     (mem_addr),
    .mem_rd       (mem_rd),
    .mem_wr       (mem_wr),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata),
    .mem_ready    (mem_ready),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask)
  );

  always #10 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // 60 ns console clock offset from the clk edges
  initial begin
    snes_sysclk = 1'b0;
    #7;
    forever #30 snes_sysclk = ~snes_sysclk;
  end

  //////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [7:0] random_byte();
    logic [31:0] r;
    r = next_rand();
    return r[23:16];
  endfunction

  function automatic int in_range(input int lo, input int n);
    logic [31:0] r;
    r = next_rand();
    return lo + int'(r[31:16] % n);
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else fail_stop($sformatf("Error: %s expected 0x%0h actual 0x%0h", name, exp, act));
  endtask

  // n rising edges and then the drive delay
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic wait_mem_idle();
    int t;
    t = 0;
    while (mem_busy && t < 100) begin
      step(1);
      t++;
    end
    if (mem_busy) begin
      fail_stop("memory request still outstanding after 100 cycles");
    end
    step(6);
  endtask

  // mode 0 MSB first with miso sampled just before the rising sck
  task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    for (i = 7; i >= 0; i--) begin
      mosi = tx[i];
      step(8);
      rx[i] = miso;
      sck = 1'b1;
      step(8);
      sck = 1'b0;
    end
    step(20);
  endtask

  task automatic transfer(input int n);
    int         k;
    logic [7:0] r;
    ss_n = 1'b0;
    step(4);
    for (k = 0; k < n; k++) begin
      shift_byte(tx_buf[k], r);
      rx_buf[k] = r;
    end
    ss_n = 1'b1;
    step(8);
    wait_mem_idle();
  endtask

  task automatic set_addr(input logic [ADDR_W-1:0] a);
    tx_buf[0] = {grp_addr, 4'h0};
    tx_buf[1] = a[23:16];
    tx_buf[2] = a[15:8];
    tx_buf[3] = a[7:0];
    transfer(4);
    check_eq("addr set", 32'(a), 32'(mem_addr));
  endtask

  task automatic load_mask(input logic [3:0] grp, input logic [ADDR_W-1:0] m);
    tx_buf[0] = {grp, 4'h0};
    tx_buf[1] = m[23:16];
    tx_buf[2] = m[15:8];
    tx_buf[3] = m[7:0];
    transfer(4);
  endtask

  //////////////////////////////////////////////////
  // memory model on the low 8 address bits with 2 to 6 cycles of latency

  always @(negedge clk) begin : mem_model
    int         dly;
    logic [7:0] idx;
    if (arst_n && (mem_rd || mem_wr)) begin
      mem_busy = 1'b1;
      idx = mem_addr[7:0];
      if (mem_wr) begin
        mem[idx] = mem_wdata;
        if (wr_cnt < 32) begin
          wr_addr_log[wr_cnt] = mem_addr;
          wr_data_log[wr_cnt] = mem_wdata;
        end
        wr_cnt++;
      end
      dly = in_range(2, 5);
      repeat (dly) @(posedge clk);
      #2;
      mem_rdata = mem[idx];
      mem_ready = 1'b1;
      repeat (2) @(posedge clk);
      #2;
      mem_ready = 1'b0;
      mem_busy  = 1'b0;
    end
  end

  initial begin : watchdog
    while (cyc < CYCLE_LIMIT) @(posedge clk);
    fail_stop("timeout, test sequence did not finish in time");
  end

  always @(negedge clk) begin
    assert (u_dut.u_assert.err_cnt == 0)
    else fail_stop("a memory port assertion failed in the bound checker");
  end

  //////////////////////////////////////////////////
  // test sequence

  initial begin
    int                k;
    int                it;
    int                n;
    logic [31:0]       r;
    logic [31:0]       freq;
    logic [2:0]        exp_map;
    logic [ADDR_W-1:0] exp_rom;
    logic [ADDR_W-1:0] exp_sram;
    logic [ADDR_W-1:0] start;
    logic [ADDR_W-1:0] exp_a;

    seed      = 32'h7cfc5978;
    clk       = 1'b0;
    arst_n    = 1'b0;
    sck       = 1'b0;
    mosi      = 1'b0;
    ss_n      = 1'b1;
    mem_rdata = 8'h00;
    mem_ready = 1'b0;
    mem_busy  = 1'b0;
    wr_cnt    = 0;
    for (k = 0; k < 256; k++) begin
      mem[k] = 8'(k * 8'h3b) ^ 8'hc6;
    end
    step(4);
    arst_n = 1'b1;

    // reset values and idle memory port
    check_eq("reset mapper", 32'(map_lorom), 32'(mapper));
    check_eq("reset rom_mask", 0, 32'(rom_mask));
    check_eq("reset saveram_mask", 0, 32'(saveram_mask));
    check_eq("reset miso", 0, 32'(miso));
    for (k = 0; k < 10; k++) begin
      step(1);
      check_eq("idle mem_rd", 0, 32'(mem_rd));
      check_eq("idle mem_wr", 0, 32'(mem_wr));
    end
    tx_buf[0] = q_sig;
    tx_buf[1] = 8'h00;
    transfer(2);
    check_eq("signature", 32'(SIG_BYTE), 32'(rx_buf[1]));

    // echo of random length
    n = in_range(3, 10);
    tx_buf[0] = q_echo;
    for (k = 1; k < n; k++) begin
      tx_buf[k] = random_byte();
    end
    transfer(n);
    for (k = 2; k < n; k++) begin
      check_eq("echo", 32'(tx_buf[k-1]), 32'(rx_buf[k]));
    end

    // configuration registers
    exp_rom  = '0;
    exp_sram = '0;
    for (it = 0; it < 4; it++) begin
      r = next_rand();
      exp_map = r[10:8];
      tx_buf[0] = {grp_mapper, 1'b0, exp_map};
      transfer(1);
      r = next_rand();
      exp_rom = r[31:8];
      load_mask(grp_rom_mask, exp_rom);
      r = next_rand();
      exp_sram = r[31:8];
      load_mask(grp_sram_mask, exp_sram);
      check_eq("mapper", 32'(exp_map), 32'(mapper));
      check_eq("rom_mask", 32'(exp_rom), 32'(rom_mask));
      check_eq("saveram_mask", 32'(exp_sram), 32'(saveram_mask));
    end

    // write burst with auto-increment
    r = next_rand();
    start = r[31:8];
    set_addr(start);
    n = in_range(4, 9);
    tx_buf[0] = {grp_write, 4'h0} | (8'd1 << INC_BIT);
    for (k = 1; k <= n; k++) begin
      tx_buf[k] = random_byte();
      wdat[k-1] = tx_buf[k];
    end
    wr_cnt = 0;
    transfer(n + 1);
    check_eq("write count", 32'(n), 32'(wr_cnt));
    for (k = 0; k < n; k++) begin
      exp_a = start + ADDR_W'(k);
      check_eq("write addr", 32'(exp_a), 32'(wr_addr_log[k]));
      check_eq("write data", 32'(wdat[k]), 32'(wr_data_log[k]));
    end
    exp_a = start + ADDR_W'(n);
    check_eq("addr after write", 32'(exp_a), 32'(mem_addr));

    // read burst with auto-increment and one read per byte
    set_addr(start);
    tx_buf[0] = {grp_read, 4'h0} | (8'd1 << INC_BIT);
    for (k = 1; k <= n; k++) begin
      tx_buf[k] = 8'h00;
    end
    transfer(n + 1);
    for (k = 1; k <= n; k++) begin
      check_eq("read inc", 32'(wdat[k-1]), 32'(rx_buf[k]));
    end
    exp_a = start + ADDR_W'(n + 1);
    check_eq("addr after read inc", 32'(exp_a), 32'(mem_addr));

    // read without increment stays on the start address
    set_addr(start);
    tx_buf[0] = {grp_read, 4'h0};
    for (k = 1; k <= 4; k++) begin
      tx_buf[k] = 8'h00;
    end
    transfer(5);
    for (k = 1; k <= 4; k++) begin
      check_eq("read no inc", 32'(wdat[0]), 32'(rx_buf[k]));
    end
    check_eq("addr after read no inc", 32'(start), 32'(mem_addr));

    // frequency query after at least one full gate window
    while (cyc < 2 * GATE + 200) begin
      step(1);
    end
    tx_buf[0] = q_freq;
    for (k = 1; k <= 4; k++) begin
      tx_buf[k] = 8'h00;
    end
    transfer(5);
    freq = {rx_buf[1], rx_buf[2], rx_buf[3], rx_buf[4]};
    assert (freq >= 32'd999 && freq <= 32'd1001)
    else fail_stop($sformatf("Error: freq expected 1000 +/- 1 actual %0d", freq));

    if (u_dut.u_assert.err_cnt == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      fail_stop("a memory port assertion failed in the bound checker");
    end
  end

endmodule

/* cart_ctrl.f */
logic/cart_mem_pkg.sv
logic/mcu_cmd_pkg.sv
logic/spi_slave.sv
logic/mcu_cmd.sv
logic/mem_req.sv
logic/clk_meter.sv
logic/cart_ctrl.sv
dv/cart_ctrl_assert.sv
dv/cart_ctrl_tb.sv
